// ==== hw/ip2_pkg.sv ====
/*
 * Shared definitions for the pixel ASIC firmware test block.
 * Field widths, status bit positions, configuration and strobe
 * structs, the ASIC pin bundle and the sequencer encodings
 */
`default_nettype none

package ip2_pkg;

  // ----------------------------------------
  // Widths
  localparam int bx_w     = 6;   // Bunch-crossing counter
  localparam int addr_lsb = 16;  // Address field sits in sw_write24[23:16]
  localparam int pat_w    = 16;  // Pattern memory word
  localparam int rd_w     = 32;  // Readout and status word

  // Status bit positions
  localparam int st_reset        = 0;
  localparam int st_w_cfg_static = 1;
  localparam int st_r_cfg_static = 2;
  localparam int st_w_cfg_array  = 3;
  localparam int st_r_cfg_array  = 4;
  localparam int st_r_data_array = 5;
  localparam int st_w_execute    = 6;
  localparam int st_done1        = 12;
  localparam int st_done2        = 13;
  localparam int st_cfg_error    = 31;

  // ----------------------------------------
  // Software strobes, w_execute is a held level
  typedef struct packed {
    logic w_cfg_static;
    logic r_cfg_static;
    logic w_cfg_array;
    logic r_cfg_array;
    logic r_data_array;
    logic w_status_clear;
    logic w_execute;
  } op_strobe_t;

  // Static word, bx_period in the low bits
  typedef struct packed {
    logic [10:0]     spare;
    logic            super_pixel_sel;
    logic            bx_delay_sign;    // Inverts bxclk
    logic [4:0]      bx_delay;         // bxclk delay in cycles
    logic [bx_w-1:0] bx_period;        // 4 or more
  } static_cfg_t;

  // sw_write24 as seen during execute
  typedef struct packed {
    logic            mask_reset_not;
    logic [bx_w-1:0] trig_phase;
    logic            loopback;         // Capture scan_in instead of scan_out
    logic [3:0]      test_number;
    logic [bx_w-1:0] test_sample;      // Sample point within the bx period
    logic [bx_w-1:0] test_delay;
  } exec_cfg_t;

  typedef enum logic [3:0] {
    TEST_1 = 4'd1,
    TEST_2 = 4'd2
  } test_sel_e;

  // Level of the ASIC scan_load pin
  typedef enum logic {
    SHIFT_REG = 1'b0,
    LOAD_COMP = 1'b1
  } scan_mode_e;

  // Request from one sequencer to the arbiter
  typedef struct packed {
    logic       load;
    logic       shift;
    logic       capture;
    logic       reset_not;
    scan_mode_e scan_load;
    logic       trig_out;
    logic       done;
  } seq_req_t;

  // Outputs to the ASIC
  typedef struct packed {
    logic super_pixel_sel;
    logic reset_not;
    logic bxclk_ana;
    logic bxclk;
    logic trig_out;             // vin_test_trig_out
    logic scan_in;
    logic scan_load;
  } dut_pins_t;

  // ----------------------------------------
  typedef enum logic [2:0] {
    T1_IDLE,
    T1_DELAY,
    T1_RESET_NOT,
    T1_SHIFT,
    T1_DONE
  } t1_state_e;

  typedef enum logic [2:0] {
    T2_IDLE,
    T2_DELAY,
    T2_RESET_NOT,
    T2_SCANLOAD_1,
    T2_SCANLOAD_2,
    T2_SHIFT,
    T2_DONE
  } t2_state_e;

endpackage

`default_nettype wire

// ==== hw/ip2_sw_regs.sv ====
/*
 * Software register block. Gates the strobes with the device enable,
 * holds the static word and pattern memory, muxes the readout word
 * and keeps the sticky status register
 */
`default_nettype none

module ip2_sw_regs import ip2_pkg::*; #(
  parameter int chain_bits = 64
) (
  input  logic                  fw_pl_clk1,
  input  logic                  op_code_w_reset,
  input  logic                  dev_id_enable,
  input  op_strobe_t            op,
  input  logic [23:0]           sw_write24,
  input  logic [chain_bits-1:0] capture,
  input  logic                  done1,
  input  logic                  done2,
  input  logic                  cfg_error,
  output static_cfg_t           static_cfg,
  output logic [chain_bits-1:0] pattern,
  output logic                  execute,
  output exec_cfg_t             exec_cfg,
  output logic [rd_w-1:0]       read_data32,
  output logic [rd_w-1:0]       read_status32
);

  localparam int pat_words = chain_bits / pat_w;  // 16-bit pattern words
  localparam int cap_words = chain_bits / rd_w;   // 32-bit capture words

  op_strobe_t                      op_g;      // Strobes after device enable
  logic [7:0]                      addr;
  logic [8:0]                      addr_p1;   // One wider, no wrap at 255
  logic [pat_words-1:0][pat_w-1:0] pat_mem;
  logic [cap_words-1:0][rd_w-1:0]  cap_arr;
  logic [pat_w-1:0]                rd_lo;
  logic [pat_w-1:0]                rd_hi;

  assign op_g     = dev_id_enable ? op : '0;
  assign addr     = sw_write24[addr_lsb +: 8];
  assign addr_p1  = {1'b0, addr} + 9'd1;
  assign execute  = op_g.w_execute;
  assign exec_cfg = exec_cfg_t'(sw_write24);     // Held by software during execute
  assign pattern  = pat_mem;                     // Word 0 lands in bit 0 of the chain
  assign cap_arr  = capture;

  // ----------------------------------------
  // Configuration writes
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      static_cfg <= '0;
      pat_mem    <= '0;
    end else begin
      if (op_g.w_cfg_static) begin
        static_cfg <= static_cfg_t'(sw_write24);
      end
      if (op_g.w_cfg_array && (addr < pat_words)) begin
        pat_mem[addr] <= sw_write24[pat_w-1:0];  // Out of range is dropped
      end
    end
  end

  // ----------------------------------------
  // Readout word, valid in the cycle of the read strobe
  always_comb begin
    rd_lo       = (addr < pat_words)    ? pat_mem[addr]    : '0;
    rd_hi       = (addr_p1 < pat_words) ? pat_mem[addr_p1] : '0;
    read_data32 = '0;
    if (op_g.r_cfg_static) begin
      read_data32 = {8'h00, static_cfg};
    end else if (op_g.r_cfg_array) begin
      read_data32 = {rd_hi, rd_lo};              // Two words per read
    end else if (op_g.r_data_array && (addr < cap_words)) begin
      read_data32 = cap_arr[addr];
    end
  end

  // ----------------------------------------
  // Sticky status, clear wins
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      read_status32           <= '0;
      read_status32[st_reset] <= 1'b1;
    end else if (op_g.w_status_clear) begin
      read_status32 <= '0;
    end else begin
      if (op_g.w_cfg_static) read_status32[st_w_cfg_static] <= 1'b1;
      if (op_g.r_cfg_static) read_status32[st_r_cfg_static] <= 1'b1;
      if (op_g.w_cfg_array)  read_status32[st_w_cfg_array]  <= 1'b1;
      if (op_g.r_cfg_array)  read_status32[st_r_cfg_array]  <= 1'b1;
      if (op_g.r_data_array) read_status32[st_r_data_array] <= 1'b1;
      if (op_g.w_execute)    read_status32[st_w_execute]    <= 1'b1;
      read_status32[st_done1]     <= done1;        // Follows, not sticky
      read_status32[st_done2]     <= done2;
      read_status32[st_cfg_error] <= cfg_error;
    end
  end

endmodule

`default_nettype wire

// ==== hw/bxclk_generator.sv ====
/*
 * Bunch-crossing clock generator. Counts 1 to bx_period, forms the
 * analog clock and a delayed, optionally inverted digital clock
 */
`default_nettype none

module bxclk_generator import ip2_pkg::*; (
  input  logic            fw_pl_clk1,
  input  logic            op_code_w_reset,
  input  logic            dev_id_enable,
  input  static_cfg_t     static_cfg,
  output logic [bx_w-1:0] bx_count,
  output logic            bx_tick,
  output logic            bxclk_ana,
  output logic            bxclk
);

  logic [bx_w-1:0] cnt_nxt;
  logic            ana_nxt;   // bxclk_ana one cycle ahead
  logic [30:0]     line;      // Delay line, line[0] is bxclk_ana
  logic [31:0]     taps;      // 31 taps plus the output register give 32 stages

  always_comb begin
    cnt_nxt = bx_count;                              // Frozen while disabled
    if (dev_id_enable) begin
      if (bx_count >= static_cfg.bx_period) begin
        cnt_nxt = bx_w'(1);                          // Wrap, also recovers from 0
      end else begin
        cnt_nxt = bx_count + 1'b1;
      end
    end
  end

  // High for the first half of the period
  assign ana_nxt   = (cnt_nxt != '0) && (cnt_nxt <= (static_cfg.bx_period >> 1));
  assign bx_tick   = (bx_count == static_cfg.bx_period);
  assign taps      = {line, ana_nxt};                // Tap d gives d cycles at bxclk
  assign bxclk_ana = line[0];

  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      bx_count <= '0;
      line     <= '0;
      bxclk    <= 1'b0;
    end else begin
      bx_count <= cnt_nxt;
      line     <= {line[29:0], ana_nxt};
      bxclk    <= taps[static_cfg.bx_delay] ^ static_cfg.bx_delay_sign;
    end
  end

endmodule

`default_nettype wire

// ==== hw/scan_test1_seq.sv ====
/*
 * Test 1 sequencer. Reset pulse of one bx period, then shifts the
 * pattern into the scan chain, one bit per bx period
 */
`default_nettype none

module scan_test1_seq import ip2_pkg::*; #(
  parameter int chain_bits = 64
) (
  input  logic            fw_pl_clk1,
  input  logic            op_code_w_reset,
  input  logic            grant,
  input  logic [bx_w-1:0] bx_count,
  input  logic            bx_tick,
  input  exec_cfg_t       exec_cfg,
  output seq_req_t        req
);

  localparam int cnt_w = $clog2(chain_bits);

  t1_state_e        state;
  t1_state_e        state_nxt;
  logic             grant_q;     // For the grant rising edge
  logic [cnt_w-1:0] shift_cnt;   // Shifts done so far
  logic             last_shift;

  assign last_shift = (shift_cnt == cnt_w'(chain_bits - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      T1_IDLE:      if (grant && !grant_q)                state_nxt = T1_DELAY;
      T1_DELAY:     if (bx_count == exec_cfg.test_delay)  state_nxt = T1_RESET_NOT;
      T1_RESET_NOT: if (bx_tick)                          state_nxt = T1_SHIFT;
      T1_SHIFT:     if (bx_tick && last_shift)            state_nxt = T1_DONE;
      T1_DONE:      state_nxt = T1_DONE;                  // Until grant drops
      default:      state_nxt = T1_IDLE;
    endcase
    if (!grant) begin
      state_nxt = T1_IDLE;                                // Abort from any state
    end
  end

  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      state     <= T1_IDLE;
      grant_q   <= 1'b0;
      shift_cnt <= '0;
    end else begin
      state   <= state_nxt;
      grant_q <= grant;
      if (state != T1_SHIFT) begin
        shift_cnt <= '0;
      end else if (bx_tick) begin
        shift_cnt <= shift_cnt + 1'b1;
      end
    end
  end

  // Request to the arbiter
  always_comb begin
    req           = '0;                                   // No trigger in test 1
    req.load      = (state == T1_RESET_NOT) && bx_tick;   // Chain takes pattern here
    req.shift     = (state == T1_SHIFT) && bx_tick;
    req.capture   = (state == T1_SHIFT);
    req.reset_not = (state == T1_RESET_NOT) ? exec_cfg.mask_reset_not : grant;
    req.scan_load = (state == T1_SHIFT) ? SHIFT_REG : LOAD_COMP;
    req.done      = (state == T1_DONE);
  end

endmodule

`default_nettype wire

// ==== hw/scan_test2_seq.sv ====
/*
 * Test 2 sequencer. Reset pulse, a two period parallel-load window
 * carrying the trigger pulse, then the pattern shift-in
 */
`default_nettype none

module scan_test2_seq import ip2_pkg::*; #(
  parameter int chain_bits = 64
) (
  input  logic            fw_pl_clk1,
  input  logic            op_code_w_reset,
  input  logic            grant,
  input  logic [bx_w-1:0] bx_count,
  input  logic            bx_tick,
  input  exec_cfg_t       exec_cfg,
  output seq_req_t        req
);

  localparam int cnt_w = $clog2(chain_bits);

  t2_state_e        state;
  t2_state_e        state_nxt;
  logic             grant_q;
  logic [cnt_w-1:0] shift_cnt;
  logic             last_shift;
  logic             trig_1;      // Tail of the pulse in the first load period
  logic             trig_2;      // Head of the pulse in the second

  assign last_shift = (shift_cnt == cnt_w'(chain_bits - 1));
  assign trig_1     = (state == T2_SCANLOAD_1) && (bx_count > exec_cfg.trig_phase);
  assign trig_2     = (state == T2_SCANLOAD_2) && (bx_count <= exec_cfg.trig_phase);

  always_comb begin
    state_nxt = state;
    case (state)
      T2_IDLE:       if (grant && !grant_q)               state_nxt = T2_DELAY;
      T2_DELAY:      if (bx_count == exec_cfg.test_delay) state_nxt = T2_RESET_NOT;
      T2_RESET_NOT:  if (bx_tick)                         state_nxt = T2_SCANLOAD_1;
      T2_SCANLOAD_1: if (bx_tick)                         state_nxt = T2_SCANLOAD_2;
      T2_SCANLOAD_2: if (bx_tick)                         state_nxt = T2_SHIFT;
      T2_SHIFT:      if (bx_tick && last_shift)           state_nxt = T2_DONE;
      T2_DONE:       state_nxt = T2_DONE;
      default:       state_nxt = T2_IDLE;
    endcase
    if (!grant) begin
      state_nxt = T2_IDLE;
    end
  end

  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      state     <= T2_IDLE;
      grant_q   <= 1'b0;
      shift_cnt <= '0;
    end else begin
      state   <= state_nxt;
      grant_q <= grant;
      if (state != T2_SHIFT) begin
        shift_cnt <= '0;
      end else if (bx_tick) begin
        shift_cnt <= shift_cnt + 1'b1;                    // Stops with the FSM at DONE
      end
    end
  end

  // ----------------------------------------
  // Request to the arbiter
  always_comb begin
    req           = '0;
    req.load      = (state == T2_SCANLOAD_2) && bx_tick;  // Load at end of window
    req.shift     = (state == T2_SHIFT) && bx_tick;
    req.capture   = (state == T2_SHIFT);
    req.reset_not = (state == T2_RESET_NOT) ? exec_cfg.mask_reset_not : grant;
    req.scan_load = (state == T2_SHIFT) ? SHIFT_REG : LOAD_COMP;
    req.trig_out  = trig_1 || trig_2;                     // One bx period wide
    req.done      = (state == T2_DONE);
  end

endmodule

`default_nettype wire

// ==== hw/scan_chain_arbiter.sv ====
/*
 * Scan-chain arbiter. Decodes the test number into grants, owns the
 * shared scan chain and capture register, flags bad settings and
 * drives the ASIC pins from the granted sequencer
 */
`default_nettype none

module scan_chain_arbiter import ip2_pkg::*; #(
  parameter int chain_bits = 64
) (
  input  logic                  fw_pl_clk1,
  input  logic                  op_code_w_reset,
  input  logic                  execute,
  input  exec_cfg_t             exec_cfg,
  input  static_cfg_t           static_cfg,
  input  logic [chain_bits-1:0] pattern,
  input  logic [bx_w-1:0]       bx_count,
  input  logic                  bxclk_ana,
  input  logic                  bxclk,
  input  seq_req_t              req1,
  input  seq_req_t              req2,
  input  logic                  scan_out,
  output logic                  grant1,
  output logic                  grant2,
  output logic [chain_bits-1:0] capture,
  output logic                  done1,
  output logic                  done2,
  output logic                  cfg_error,
  output dut_pins_t             dut_pins
);

  logic                  g1_nxt;
  logic                  g2_nxt;
  seq_req_t              req;      // Request of the granted sequencer
  logic [chain_bits-1:0] chain;    // Shared scan-in chain
  logic                  scan_in;

  assign g1_nxt  = execute && (exec_cfg.test_number == TEST_1);
  assign g2_nxt  = execute && (exec_cfg.test_number == TEST_2);
  assign scan_in = chain[0];
  assign done1   = grant1 && req1.done;
  assign done2   = grant2 && req2.done;

  // ----------------------------------------
  // Grants and the settings check
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      grant1    <= 1'b0;
      grant2    <= 1'b0;
      cfg_error <= 1'b0;
    end else begin
      grant1 <= g1_nxt;                                 // Other numbers grant nothing
      grant2 <= g2_nxt;
      if ((g1_nxt || g2_nxt) && !(grant1 || grant2)) begin
        // Checked once per run, the test still goes ahead
        cfg_error <= (exec_cfg.test_delay < 3) ||
                     (exec_cfg.test_delay > static_cfg.bx_period);
      end
    end
  end

  always_comb begin
    req = '0;
    if (grant1) begin
      req = req1;
    end else if (grant2) begin
      req = req2;
    end
  end

  // ----------------------------------------
  // Shared chain and capture register
  always_ff @(posedge fw_pl_clk1) begin
    if (op_code_w_reset) begin
      chain <= '0;                                      // scan_in reaches a pin
    end else if (req.load) begin
      chain <= pattern;
    end else if (req.shift) begin
      chain <= {1'b0, chain[chain_bits-1:1]};           // Bit 0 leaves first
    end
  end

  always_ff @(posedge fw_pl_clk1) begin
    if (req.capture && (bx_count == exec_cfg.test_sample)) begin
      capture <= {exec_cfg.loopback ? scan_in : scan_out, capture[chain_bits-1:1]};
    end
  end

  // Pins are all 0 without a grant
  always_comb begin
    dut_pins = '0;
    if (grant1 || grant2) begin
      dut_pins.super_pixel_sel = static_cfg.super_pixel_sel;
      dut_pins.reset_not       = req.reset_not;
      dut_pins.bxclk_ana       = bxclk_ana;
      dut_pins.bxclk           = bxclk;
      dut_pins.trig_out        = req.trig_out;
      dut_pins.scan_in         = scan_in;
      dut_pins.scan_load       = req.scan_load;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fw_ip2.sv ====
/*
 * Firmware test block for the pixel ASIC, top level.
 * Ties the register block, bx clocks, arbiter and both sequencers
 */
`default_nettype none

module fw_ip2 import ip2_pkg::*; #(
  parameter int chain_bits = 64     // Multiple of 32
) (
  input  logic        fw_pl_clk1,
  input  logic        op_code_w_reset,
  input  logic        dev_id_enable,
  input  op_strobe_t  op,
  input  logic [23:0] sw_write24,
  output logic [31:0] read_data32,
  output logic [31:0] read_status32,
  output dut_pins_t   dut_pins,
  input  logic        scan_out
);

  static_cfg_t           static_cfg;
  exec_cfg_t             exec_cfg;
  logic [chain_bits-1:0] pattern;
  logic [chain_bits-1:0] capture;
  logic                  execute;
  logic                  done1;
  logic                  done2;
  logic                  cfg_error;
  logic [bx_w-1:0]       bx_count;
  logic                  bx_tick;
  logic                  bxclk_ana;
  logic                  bxclk;
  logic                  grant1;
  logic                  grant2;
  seq_req_t              req1;
  seq_req_t              req2;

  // ----------------------------------------
  ip2_sw_regs #(.chain_bits(chain_bits)) i_ip2_sw_regs (
    .fw_pl_clk1, .op_code_w_reset, .dev_id_enable, .op, .sw_write24,
    .capture, .done1, .done2, .cfg_error,
    .static_cfg, .pattern, .execute, .exec_cfg, .read_data32, .read_status32
  );

  bxclk_generator i_bxclk_generator (
    .fw_pl_clk1, .op_code_w_reset, .dev_id_enable, .static_cfg,
    .bx_count, .bx_tick, .bxclk_ana, .bxclk
  );

  // Arbiter owns the chain, sequencers only request
  scan_chain_arbiter #(.chain_bits(chain_bits)) i_scan_chain_arbiter (
    .fw_pl_clk1, .op_code_w_reset, .execute, .exec_cfg, .static_cfg, .pattern,
    .bx_count, .bxclk_ana, .bxclk, .req1, .req2, .scan_out,
    .grant1, .grant2, .capture, .done1, .done2, .cfg_error, .dut_pins
  );

  scan_test1_seq #(.chain_bits(chain_bits)) i_scan_test1_seq (
    .fw_pl_clk1, .op_code_w_reset, .grant(grant1), .bx_count, .bx_tick, .exec_cfg,
    .req(req1)
  );

  scan_test2_seq #(.chain_bits(chain_bits)) i_scan_test2_seq (
    .fw_pl_clk1, .op_code_w_reset, .grant(grant2), .bx_count, .bx_tick, .exec_cfg,
    .req(req2)
  );

endmodule

`default_nettype wire

// ==== test/fw_ip2_assertions.sv ====
/*
 * Bound checks on the bunch-crossing clocks and on the ASIC pins
 * while no test is granted
 */
`default_nettype none

module fw_ip2_assertions import ip2_pkg::*; (
  input logic        fw_pl_clk1,
  input logic        op_code_w_reset,
  input logic        execute,
  input logic        grant1,
  input logic        grant2,
  input static_cfg_t static_cfg,
  input logic        bxclk_ana,
  input logic        bxclk,
  input dut_pins_t   dut_pins
);

  int          fail_count = 0;   // Read by the testbench at the end
  logic [31:0] ana_hist;         // bxclk_ana history, [0] is one cycle back
  static_cfg_t cfg_q;
  logic [5:0]  cfg_age;          // Cycles since the static word changed
  logic        stable;
  logic        ana_d;            // bxclk_ana from bx_delay cycles back

  always_ff @(posedge fw_pl_clk1) begin
    ana_hist <= {ana_hist[30:0], bxclk_ana};
    cfg_q    <= static_cfg;
    if (op_code_w_reset || (static_cfg != cfg_q)) begin
      cfg_age <= '0;
    end else if (cfg_age != 6'd63) begin
      cfg_age <= cfg_age + 1'b1;
    end
  end

  // Delay line refilled after the last change
  assign stable = (cfg_age > 6'd33) && (static_cfg == cfg_q);
  assign ana_d  = (static_cfg.bx_delay == '0) ? bxclk_ana
                                              : ana_hist[static_cfg.bx_delay - 5'd1];

  // ----------------------------------------
  bxclk_delay_a: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    stable |-> (bxclk == (ana_d ^ static_cfg.bx_delay_sign)))
    else begin fail_count++; $error("bxclk is not the delayed bxclk_ana"); end

  // Period 8, four cycles high then four low
  bxclk_ana_duty_a: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    (stable && (static_cfg.bx_period == 6'd8) && $rose(bxclk_ana))
      |-> ##4 $fell(bxclk_ana) ##4 $rose(bxclk_ana))
    else begin fail_count++; $error("bxclk_ana duty cycle wrong"); end

  clock_pins_a: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    (grant1 || grant2) |-> ((dut_pins.bxclk_ana == bxclk_ana) && (dut_pins.bxclk == bxclk)))
    else begin fail_count++; $error("Clock pins do not carry the bx clocks"); end

  idle_pins_a: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    !(grant1 || grant2) |-> (dut_pins == '0))
    else begin fail_count++; $error("ASIC pins active without a grant"); end

  exec_drop_a: assert property (@(posedge fw_pl_clk1) disable iff (op_code_w_reset)
    $fell(execute) |=> (dut_pins == '0))
    else begin fail_count++; $error("ASIC pins not idle one cycle after execute dropped"); end

endmodule

bind fw_ip2 fw_ip2_assertions i_fw_ip2_assertions (
  .fw_pl_clk1      (fw_pl_clk1),
  .op_code_w_reset (op_code_w_reset),
  .execute         (execute),
  .grant1          (grant1),
  .grant2          (grant2),
  .static_cfg      (static_cfg),
  .bxclk_ana       (bxclk_ana),
  .bxclk           (bxclk),
  .dut_pins        (dut_pins)
);

`default_nettype wire

// ==== test/fw_ip2_tb.sv ====
/*
 * Testbench for the pixel ASIC firmware test block. Drives the software
 * strobes, echoes scan_in back as the ASIC scan_out and checks read-back,
 * status, the bx clocks on the pins and both scan tests
 */
`default_nettype none

module fw_ip2_tb import ip2_pkg::*; ();

  localparam int chain_bits = 64;
  localparam int pat_words  = chain_bits / 16;
  localparam int bx_period  = 8;
  localparam int max_cycles = 4000;   // Three runs of about (4+64)*8 cycles plus register traffic

  localparam op_strobe_t op_w_static = '{w_cfg_static: 1'b1, default: 1'b0};
  localparam op_strobe_t op_r_static = '{r_cfg_static: 1'b1, default: 1'b0};
  localparam op_strobe_t op_w_array  = '{w_cfg_array: 1'b1, default: 1'b0};
  localparam op_strobe_t op_r_array  = '{r_cfg_array: 1'b1, default: 1'b0};
  localparam op_strobe_t op_r_data   = '{r_data_array: 1'b1, default: 1'b0};
  localparam op_strobe_t op_clear    = '{w_status_clear: 1'b1, default: 1'b0};
  localparam op_strobe_t op_execute  = '{w_execute: 1'b1, default: 1'b0};

  logic        fw_pl_clk1;
  logic        op_code_w_reset;
  logic        dev_id_enable;
  op_strobe_t  op;
  logic [23:0] sw_write24;
  logic [31:0] read_data32;
  logic [31:0] read_status32;
  dut_pins_t   dut_pins;
  logic        scan_out;

  integer      seed;
  int          cycles;
  logic [15:0] pat_word [pat_words];
  logic [23:0] cfg;
  logic        echo_en;          // ASIC model returns scan_in on scan_out
  logic        in_window;        // Between the reset pulse and the shift
  int          rst_low_cycles;
  int          window_cycles;
  int          trig_cycles;

  fw_ip2 #(.chain_bits(chain_bits)) i_fw_ip2 (
    .fw_pl_clk1, .op_code_w_reset, .dev_id_enable, .op, .sw_write24,
    .read_data32, .read_status32, .dut_pins, .scan_out
  );

  always #10 fw_pl_clk1 = ~fw_pl_clk1;

  // ----------------------------------------
  // Timeout, ASIC model and pin monitor
  always @(posedge fw_pl_clk1) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      end_in_failure("Timeout, the tests did not finish within the cycle limit");
    end
  end

  always @(posedge fw_pl_clk1) begin
    #2;
    scan_out = echo_en ? dut_pins.scan_in : 1'b0;   // Chain of length zero
  end

  always @(negedge fw_pl_clk1) begin
    if (dut_pins.scan_load && !dut_pins.reset_not) begin
      rst_low_cycles++;                             // Granted and in the reset pulse
      in_window = 1'b1;
    end else if (in_window && dut_pins.scan_load) begin
      window_cycles++;                              // Load window of test 2
    end else begin
      in_window = 1'b0;
    end
    if (dut_pins.trig_out) trig_cycles++;
  end

  // ----------------------------------------
  // Helpers
  task automatic end_in_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    end_in_failure($sformatf("[ERROR] %s expected 0x%08h, got 0x%08h", name, exp, act));
  endtask

  task automatic next_cycle();
    @(posedge fw_pl_clk1);
    #2;
  endtask

  // Non-read strobe leaves read_data32 at 0
  task automatic apply_op(input op_strobe_t o, input logic [23:0] data);
    op         = o;
    sw_write24 = data;
    #5;
    assert (read_data32 == 32'h0) else mismatch("read_data32", 32'h0, read_data32);
    next_cycle();
    op = '0;
  endtask

  task automatic read_expect(input op_strobe_t o, input logic [23:0] data,
                             input logic [31:0] exp);
    op         = o;
    sw_write24 = data;
    #5;                                             // Combinational read
    assert (read_data32 == exp) else mismatch("read_data32", exp, read_data32);
    next_cycle();
    op = '0;
  endtask

  task automatic status_expect(input logic [31:0] exp);
    assert (read_status32 == exp) else mismatch("read_status32", exp, read_status32);
  endtask

  function automatic logic [23:0] static_word(input int period, input int delay,
                                              input logic sign, input logic spx);
    static_cfg_t s;
    s                 = '0;
    s.bx_period       = 6'(period);
    s.bx_delay        = 5'(delay);
    s.bx_delay_sign   = sign;
    s.super_pixel_sel = spx;
    return s;
  endfunction

  function automatic logic [23:0] exec_word(input int delay, input int sample,
                                            input test_sel_e t, input logic loopback,
                                            input int phase, input logic mask);
    exec_cfg_t e;
    e                = '0;
    e.test_delay     = 6'(delay);
    e.test_sample    = 6'(sample);
    e.test_number    = t;
    e.loopback       = loopback;
    e.trig_phase     = 6'(phase);
    e.mask_reset_not = mask;
    return e;
  endfunction

  // Words a+1 and a with zero beyond the memory
  function automatic logic [31:0] pattern_pair(input int a);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = (a < pat_words) ? pat_word[a] : 16'h0;
    hi = (a + 1 < pat_words) ? pat_word[a + 1] : 16'h0;
    return {hi, lo};
  endfunction

  task automatic load_pattern();
    for (int i = 0; i < pat_words; i++) begin
      pat_word[i] = 16'($random(seed));
      apply_op(op_w_array, {8'(i), pat_word[i]});
    end
  endtask

  // Capture words hold the pattern and address 2 is past the register
  task automatic check_capture();
    for (int a = 0; a <= chain_bits / 32; a++) begin
      read_expect(op_r_data, {8'(a), 16'h0}, (a < chain_bits / 32) ? pattern_pair(2 * a) : '0);
    end
  endtask

  // Holds execute until the done status bit shows and then drops it
  task automatic run_scan_test(input logic [23:0] word, input int done_bit, input logic exp_err,
                               input logic exp_spx);
    apply_op(op_clear, 24'h0);
    rst_low_cycles = 0;
    window_cycles  = 0;
    trig_cycles    = 0;
    sw_write24     = word;
    op             = op_execute;
    while (!read_status32[done_bit]) next_cycle();
    assert (read_status32[st_w_execute])
      else mismatch("read_status32[6]", 32'h1, 32'(read_status32[st_w_execute]));
    assert (read_status32[st_cfg_error] == exp_err)
      else mismatch("read_status32[31]", 32'(exp_err), 32'(read_status32[st_cfg_error]));
    assert (dut_pins.super_pixel_sel == exp_spx)
      else mismatch("dut_pins.super_pixel_sel", 32'(exp_spx), 32'(dut_pins.super_pixel_sel));
    op         = '0;
    sw_write24 = '0;
    next_cycle();
    assert (dut_pins == '0) else mismatch("dut_pins", 32'h0, 32'(dut_pins));
  endtask

  // ----------------------------------------
  initial begin
    fw_pl_clk1      = 1'b0;
    op_code_w_reset = 1'b1;
    dev_id_enable   = 1'b1;
    op              = '0;
    sw_write24      = '0;
    scan_out        = 1'b0;
    echo_en         = 1'b0;
    in_window       = 1'b0;
    seed            = 32'h0ac7_7cf0;
    cycles          = 0;
    rst_low_cycles  = 0;
    window_cycles   = 0;
    trig_cycles     = 0;
    repeat (16) @(posedge fw_pl_clk1);
    #2;
    op_code_w_reset = 1'b0;
    status_expect(32'h1 << st_reset);
    assert (dut_pins == '0) else mismatch("dut_pins", 32'h0, 32'(dut_pins));

    // Static word and status bits with one strobe at a time
    apply_op(op_clear, 24'h0);
    status_expect(32'h0);
    cfg = static_word(bx_period, 3, 1'b1, 1'b1);
    apply_op(op_w_static, cfg);
    status_expect(32'h1 << st_w_cfg_static);
    apply_op(op_clear, 24'h0);
    read_expect(op_r_static, 24'h0, {8'h00, cfg});
    status_expect(32'h1 << st_r_cfg_static);

    // Pattern memory where the write at address 5 is dropped
    apply_op(op_clear, 24'h0);
    load_pattern();
    apply_op(op_w_array, {8'd5, 16'hdead});
    status_expect(32'h1 << st_w_cfg_array);
    apply_op(op_clear, 24'h0);
    for (int a = 0; a <= pat_words; a++) begin
      read_expect(op_r_array, {8'(a), 16'h0}, pattern_pair(a));
    end
    status_expect(32'h1 << st_r_cfg_array);

    // ----------------------------------------
    // Test 1 in loopback with reset masked and test_delay too small
    run_scan_test(exec_word(1, 4, TEST_1, 1'b1, 0, 1'b1), st_done1, 1'b1, 1'b1);
    assert (rst_low_cycles == 0) else mismatch("reset_not low cycles", 32'h0, rst_low_cycles);
    apply_op(op_clear, 24'h0);
    check_capture();
    assert (read_status32[st_r_data_array])
      else end_in_failure("r_data_array did not set its status bit");

    // Test 1 again on a fresh pattern with a delay equal to the period for a full reset period
    load_pattern();
    run_scan_test(exec_word(bx_period, 6, TEST_1, 1'b1, 0, 1'b0), st_done1, 1'b0, 1'b1);
    assert (rst_low_cycles == bx_period)
      else mismatch("reset_not low cycles", bx_period, rst_low_cycles);
    assert (trig_cycles == 0) else mismatch("trig_out cycles", 32'h0, trig_cycles);
    check_capture();

    // Test 2 through the echoed scan_out with a new pattern and undelayed bxclk
    cfg = static_word(bx_period, 0, 1'b0, 1'b0);
    apply_op(op_w_static, cfg);
    read_expect(op_r_static, 24'h0, {8'h00, cfg});
    load_pattern();
    echo_en = 1'b1;
    run_scan_test(exec_word(5, bx_period, TEST_2, 1'b0, 3, 1'b0), st_done2, 1'b0, 1'b0);
    echo_en = 1'b0;
    assert (window_cycles == 2 * bx_period)
      else mismatch("scan_load window cycles", 2 * bx_period, window_cycles);
    assert (trig_cycles == bx_period) else mismatch("trig_out cycles", bx_period, trig_cycles);
    check_capture();

    if (i_fw_ip2.i_fw_ip2_assertions.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      end_in_failure("Bound assertions on the DUT reported failures");
    end
  end

endmodule

`default_nettype wire

// ==== fw_ip2.f ====
hw/ip2_pkg.sv
hw/ip2_sw_regs.sv
hw/bxclk_generator.sv
hw/scan_test1_seq.sv
hw/scan_test2_seq.sv
hw/scan_chain_arbiter.sv
hw/fw_ip2.sv
test/fw_ip2_assertions.sv
test/fw_ip2_tb.sv

// ==== Bender.yml ====
package:
  name: fw_ip2

sources:
  - hw/ip2_pkg.sv
  - hw/ip2_sw_regs.sv
  - hw/bxclk_generator.sv
  - hw/scan_test1_seq.sv
  - hw/scan_test2_seq.sv
  - hw/scan_chain_arbiter.sv
  - hw/fw_ip2.sv
  - target: test
    files:
      - test/fw_ip2_assertions.sv
      - test/fw_ip2_tb.sv
